// ==== logic/cc_pkg.sv ====
/*
 * Core complex shared definitions
 * Widths, offload and memory payload structs, integer operation codes
 */
package cc_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned IdWidth      = 5;
  localparam int unsigned UnitSelWidth = 2;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned AmoWidth     = 4;

  // Unit select value owned by the local integer unit
  localparam int unsigned IntUnitSel = 0;

  // Integer operations handled by the local unit
  typedef enum logic [1:0] {
    op_add   = 2'd0,
    op_sub   = 2'd1,
    op_mul   = 2'd2,  // low word of product
    op_mulhu = 2'd3   // high word, unsigned
  } int_op_e;

  // ------------------------------
  // Offload channel
  // ------------------------------
  typedef struct packed {
    logic [UnitSelWidth-1:0] addr;
    logic [IdWidth-1:0]      id;
    int_op_e                 op;
    logic [DataWidth-1:0]    arga;
    logic [DataWidth-1:0]    argb;
    logic [DataWidth-1:0]    argc;
  } acc_req_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 error;
  } acc_resp_t;

  // ------------------------------
  // TCDM channel
  // ------------------------------
  typedef struct packed {
    logic [DataWidth-1:0] addr;
    logic                 write;
    logic [AmoWidth-1:0]  amo;
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic [IdWidth-1:0]   id;
  } dreq_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [IdWidth-1:0]   id;
    logic                 write;
    logic                 error;
  } dresp_t;

endpackage

// ==== logic/spill_register.sv ====
/*
 * Spill register, a two-entry valid/ready cut on any payload type
 * Breaks every combinational path between its sides, or wires through
 */
`timescale 1ns/1ns

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    T     a_data_q, b_data_q;
    logic a_full_q, b_full_q;
    logic a_fill, a_drain;
    logic b_fill, b_drain;

    // Slot A takes every new entry
    assign a_fill  = valid_i & ready_o;
    assign a_drain = a_full_q & ~b_full_q;

    // Slot B catches A when the output stalls
    assign b_fill  = a_drain & ~ready_i;
    assign b_drain = b_full_q & ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B always holds the older entry
    assign valid_o = a_full_q | b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = ~a_full_q | ~b_full_q;
  end

endmodule

// ==== logic/int_unit.sv ====
/*
 * Integer unit for offloaded add, sub, mul and mulhu
 * Two pipeline stages, in-order, one request per cycle
 */
`timescale 1ns/1ns

module int_unit (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cc_pkg::acc_req_t  req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output cc_pkg::acc_resp_t resp_o,
  output logic              resp_valid_o,
  input  logic              resp_ready_i
);

  typedef struct packed {
    logic [cc_pkg::IdWidth-1:0]   id;
    cc_pkg::int_op_e              op;
    logic [cc_pkg::DataWidth-1:0] a;
    logic [cc_pkg::DataWidth-1:0] b;
  } s1_t;

  s1_t                            s1_q;
  logic                           s1_valid_q;
  logic                           s2_valid_q;
  logic                           s1_en, s2_en;
  logic [2*cc_pkg::DataWidth-1:0] wide_res;
  logic [cc_pkg::DataWidth-1:0]   res;
  cc_pkg::acc_resp_t              s2_q;

  // Stage advances when its successor can take the entry
  assign s2_en = ~s2_valid_q | resp_ready_i;
  assign s1_en = ~s1_valid_q | s2_en;

  // Only a full, stalled pipe refuses input
  assign req_ready_o = s1_en;

  // ------------------------------
  // Stage 1 compute
  // ------------------------------
  always_comb begin
    case (s1_q.op)
      cc_pkg::op_add: wide_res = {{cc_pkg::DataWidth{1'b0}}, s1_q.a + s1_q.b};
      cc_pkg::op_sub: wide_res = {{cc_pkg::DataWidth{1'b0}}, s1_q.a - s1_q.b};
      default:        wide_res = s1_q.a * s1_q.b;
    endcase
  end

  // High word only for mulhu
  assign res = (s1_q.op == cc_pkg::op_mulhu) ? wide_res[2*cc_pkg::DataWidth-1:cc_pkg::DataWidth]
                                             : wide_res[cc_pkg::DataWidth-1:0];

  // ------------------------------
  // Pipeline registers
  // ------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_en) begin
        s1_valid_q <= req_valid_i;
      end
      if (s2_en) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && s1_en) begin
      s1_q.id <= req_i.id;
      s1_q.op <= req_i.op;
      s1_q.a  <= req_i.arga;
      s1_q.b  <= req_i.argb;
    end
    if (s1_valid_q && s2_en) begin
      s2_q.id    <= s1_q.id;
      s2_q.data  <= res;
      s2_q.error <= 1'b0;
    end
  end

  assign resp_o       = s2_q;
  assign resp_valid_o = s2_valid_q;

endmodule

// ==== logic/offload_router.sv ====
/*
 * Offload router, steers requests by unit select and
 * merges integer-unit and shared-port responses round-robin
 */
`timescale 1ns/1ns

module offload_router (
  input  logic              clk_i,
  input  logic              rst_i,
  // Request from the cut register
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  cc_pkg::acc_req_t  req_i,
  // Request valid/ready toward the units
  output logic              int_req_valid_o,
  input  logic              int_req_ready_i,
  output logic              sh_req_valid_o,
  input  logic              sh_req_ready_i,
  // Unit responses
  input  cc_pkg::acc_resp_t int_resp_i,
  input  logic              int_resp_valid_i,
  output logic              int_resp_ready_o,
  input  cc_pkg::acc_resp_t sh_resp_i,
  input  logic              sh_resp_valid_i,
  output logic              sh_resp_ready_o,
  // Merged response
  output cc_pkg::acc_resp_t resp_o,
  output logic              resp_valid_o,
  input  logic              resp_ready_i
);

  logic to_int;
  logic prio_sh_q;
  logic grant_int, grant_sh;

  // ------------------------------
  // Request demux
  // ------------------------------
  assign to_int = (req_i.addr == cc_pkg::UnitSelWidth'(cc_pkg::IntUnitSel));

  // Everything not owned locally goes out to the shared unit
  assign int_req_valid_o = req_valid_i & to_int;
  assign sh_req_valid_o  = req_valid_i & ~to_int;
  assign req_ready_o     = to_int ? int_req_ready_i : sh_req_ready_i;

  // ------------------------------
  // Response arbiter
  // ------------------------------
  // Integer unit wins unless the shared port holds priority
  assign grant_int = int_resp_valid_i & (~sh_resp_valid_i | ~prio_sh_q);
  assign grant_sh  = sh_resp_valid_i & ~grant_int;

  assign resp_valid_o     = grant_int | grant_sh;
  assign resp_o           = grant_sh ? sh_resp_i : int_resp_i;
  assign int_resp_ready_o = grant_int & resp_ready_i;
  assign sh_resp_ready_o  = grant_sh & resp_ready_i;

  // After a transfer the loser gets priority;
  // while stalled the current winner keeps it so the output stays stable
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      prio_sh_q <= 1'b0;
    end else if (resp_valid_o) begin
      if (resp_ready_i) begin
        prio_sh_q <= grant_int;
      end else begin
        prio_sh_q <= grant_sh;
      end
    end
  end

endmodule

// ==== logic/core_complex.sv ====
/*
 * Core complex wrapper: offload and TCDM cut registers,
 * unit router and the local integer unit
 */
`timescale 1ns/1ns

module core_complex #(
  parameter bit RegisterOffloadReq  = 1'b1,
  parameter bit RegisterOffloadResp = 1'b1,
  parameter bit RegisterTcdmReq     = 1'b0,
  parameter bit RegisterTcdmResp    = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // Offload from core
  input  cc_pkg::acc_req_t  core_acc_req_i,
  input  logic              core_acc_req_valid_i,
  output logic              core_acc_req_ready_o,
  output cc_pkg::acc_resp_t core_acc_resp_o,
  output logic              core_acc_resp_valid_o,
  input  logic              core_acc_resp_ready_i,
  // Shared accelerator port
  output cc_pkg::acc_req_t  sh_acc_req_o,
  output logic              sh_acc_req_valid_o,
  input  logic              sh_acc_req_ready_i,
  input  cc_pkg::acc_resp_t sh_acc_resp_i,
  input  logic              sh_acc_resp_valid_i,
  output logic              sh_acc_resp_ready_o,
  // TCDM
  input  cc_pkg::dreq_t     core_data_req_i,
  input  logic              core_data_req_valid_i,
  output logic              core_data_req_ready_o,
  output cc_pkg::dreq_t     data_req_o,
  output logic              data_req_valid_o,
  input  logic              data_req_ready_i,
  input  cc_pkg::dresp_t    data_resp_i,
  input  logic              data_resp_valid_i,
  output logic              data_resp_ready_o,
  output cc_pkg::dresp_t    core_data_resp_o,
  output logic              core_data_resp_valid_o,
  input  logic              core_data_resp_ready_i
);

  cc_pkg::acc_req_t  acc_req_q;
  logic              acc_req_qvalid, acc_req_qready;
  cc_pkg::acc_resp_t acc_resp_d;
  logic              acc_resp_dvalid, acc_resp_dready;
  logic              int_req_valid, int_req_ready;
  cc_pkg::acc_resp_t int_resp;
  logic              int_resp_valid, int_resp_ready;

  // ------------------------------
  // Offload path
  // ------------------------------
  spill_register #(
    .T      (cc_pkg::acc_req_t),
    .Bypass (!RegisterOffloadReq)
  ) i_spill_acc_req (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (core_acc_req_valid_i),
    .ready_o (core_acc_req_ready_o),
    .data_i  (core_acc_req_i),
    .valid_o (acc_req_qvalid),
    .ready_i (acc_req_qready),
    .data_o  (acc_req_q)
  );

  // Shared port sees every request payload, valid picks the owner
  assign sh_acc_req_o = acc_req_q;

  offload_router i_offload_router (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (acc_req_qvalid),
    .req_ready_o      (acc_req_qready),
    .req_i            (acc_req_q),
    .int_req_valid_o  (int_req_valid),
    .int_req_ready_i  (int_req_ready),
    .sh_req_valid_o   (sh_acc_req_valid_o),
    .sh_req_ready_i   (sh_acc_req_ready_i),
    .int_resp_i       (int_resp),
    .int_resp_valid_i (int_resp_valid),
    .int_resp_ready_o (int_resp_ready),
    .sh_resp_i        (sh_acc_resp_i),
    .sh_resp_valid_i  (sh_acc_resp_valid_i),
    .sh_resp_ready_o  (sh_acc_resp_ready_o),
    .resp_o           (acc_resp_d),
    .resp_valid_o     (acc_resp_dvalid),
    .resp_ready_i     (acc_resp_dready)
  );

  int_unit i_int_unit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (acc_req_q),
    .req_valid_i  (int_req_valid),
    .req_ready_o  (int_req_ready),
    .resp_o       (int_resp),
    .resp_valid_o (int_resp_valid),
    .resp_ready_i (int_resp_ready)
  );

  spill_register #(
    .T      (cc_pkg::acc_resp_t),
    .Bypass (!RegisterOffloadResp)
  ) i_spill_acc_resp (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (acc_resp_dvalid),
    .ready_o (acc_resp_dready),
    .data_i  (acc_resp_d),
    .valid_o (core_acc_resp_valid_o),
    .ready_i (core_acc_resp_ready_i),
    .data_o  (core_acc_resp_o)
  );

  // ------------------------------
  // TCDM path
  // ------------------------------
  // Output valid taken after the cut
  spill_register #(
    .T      (cc_pkg::dreq_t),
    .Bypass (!RegisterTcdmReq)
  ) i_spill_tcdm_req (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (core_data_req_valid_i),
    .ready_o (core_data_req_ready_o),
    .data_i  (core_data_req_i),
    .valid_o (data_req_valid_o),
    .ready_i (data_req_ready_i),
    .data_o  (data_req_o)
  );

  spill_register #(
    .T      (cc_pkg::dresp_t),
    .Bypass (!RegisterTcdmResp)
  ) i_spill_tcdm_resp (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (data_resp_valid_i),
    .ready_o (data_resp_ready_o),
    .data_i  (data_resp_i),
    .valid_o (core_data_resp_valid_o),
    .ready_i (core_data_resp_ready_i),
    .data_o  (core_data_resp_o)
  );

endmodule

// ==== include/cc_tb_checks.svh ====
/*
 * Core complex testbench compare tasks and error counters
 */
`ifndef CC_TB_CHECKS_SVH
`define CC_TB_CHECKS_SVH

int value_errs = 0;
int other_errs = 0;

task automatic check_acc_req(input string name, input cc_pkg::acc_req_t exp,
                             input cc_pkg::acc_req_t act);
  if (act !== exp) begin
    value_errs++;
    $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, act);
  end
endtask

task automatic check_acc_resp(input string name, input cc_pkg::acc_resp_t exp,
                              input cc_pkg::acc_resp_t act);
  if (act !== exp) begin
    value_errs++;
    $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, act);
  end
endtask

task automatic check_dreq(input string name, input cc_pkg::dreq_t exp,
                          input cc_pkg::dreq_t act);
  if (act !== exp) begin
    value_errs++;
    $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, act);
  end
endtask

task automatic check_dresp(input string name, input cc_pkg::dresp_t exp,
                           input cc_pkg::dresp_t act);
  if (act !== exp) begin
    value_errs++;
    $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, act);
  end
endtask

// Failures that have no value pair
task automatic report_problem(input string what);
  other_errs++;
  $display("Failure @ %0t: %s", $time, what);
endtask

`endif

// ==== tests/tb_core_complex.sv ====
/*
 * Core complex testbench, random offload and TCDM traffic
 * with shared-unit and memory responders checked against a model
 */
`timescale 1ns/1ns

module tb_core_complex;

  localparam int NumAcc    = 1000;
  localparam int NumMem    = 300;
  localparam int MaxCycles = (NumAcc + NumMem) * 30 + 1000;

  `include "cc_tb_checks.svh"

  logic              clk_i, rst_i, rst_d, run_en;
  cc_pkg::acc_req_t  core_acc_req_i, sh_acc_req_o;
  logic              core_acc_req_valid_i, core_acc_req_ready_o;
  cc_pkg::acc_resp_t core_acc_resp_o, sh_acc_resp_i;
  logic              core_acc_resp_valid_o, core_acc_resp_ready_i;
  logic              sh_acc_req_valid_o, sh_acc_req_ready_i;
  logic              sh_acc_resp_valid_i, sh_acc_resp_ready_o;
  cc_pkg::dreq_t     core_data_req_i, data_req_o;
  logic              core_data_req_valid_i, core_data_req_ready_o;
  logic              data_req_valid_o, data_req_ready_i;
  cc_pkg::dresp_t    data_resp_i, core_data_resp_o, mem_rsp;
  logic              data_resp_valid_i, data_resp_ready_o;
  logic              core_data_resp_valid_o, core_data_resp_ready_i;

  // Model state, expected offload responses indexed by id
  cc_pkg::acc_resp_t exp_resp [32];
  logic [31:0]       exp_busy;
  cc_pkg::acc_req_t  sh_exp_q[$], sh_pend_q[$], sh_head;
  cc_pkg::dreq_t     dreq_exp_q[$];
  cc_pkg::dresp_t    dresp_exp_q[$], mem_pend_q[$];
  int acc_sent = 0, acc_rcvd = 0, mem_sent = 0, mem_rcvd = 0;
  int outstanding = 0, id_ptr = 0, sh_delay = -1, cycle_cnt = 0;
  logic acc_req_done = 0, sh_resp_done = 0, dreq_done = 0, dresp_done = 0;

  core_complex UUT (.*);

  always #20 clk_i = ~clk_i;

  // Integer unit reference, results wrap to 32 bits
  function automatic logic [31:0] int_model(input cc_pkg::int_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [63:0] prod;
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      cc_pkg::op_add: return a + b;
      cc_pkg::op_sub: return a - b;
      cc_pkg::op_mul: return prod[31:0];
      default:        return prod[63:32];
    endcase
  endfunction

  task automatic issue_acc_req();
    cc_pkg::acc_req_t  req;
    cc_pkg::acc_resp_t exp;
    // Next id that is not in flight
    while (exp_busy[id_ptr]) begin
      id_ptr = (id_ptr + 1) % 32;
    end
    req.addr = 2'($urandom_range(3));
    req.id   = 5'(id_ptr);
    req.op   = cc_pkg::int_op_e'($urandom_range(3));
    req.arga = $urandom();
    req.argb = $urandom();
    req.argc = $urandom();
    exp.id   = req.id;
    if (req.addr == 2'd0) begin
      exp.data  = int_model(req.op, req.arga, req.argb);
      exp.error = 1'b0;
    end else begin
      exp.data  = req.arga ^ req.argb;
      exp.error = req.argc[0];
      sh_exp_q.push_back(req);
    end
    exp_resp[id_ptr] = exp;
    exp_busy[id_ptr] = 1'b1;
    id_ptr = (id_ptr + 1) % 32;
    outstanding++;
    acc_sent++;
    core_acc_req_i = req;
    core_acc_req_valid_i = 1'b1;
  endtask

  task automatic issue_mem_req();
    cc_pkg::dreq_t req;
    req.addr  = $urandom();
    req.write = 1'($urandom_range(1));
    req.amo   = 4'($urandom_range(15));
    req.data  = $urandom();
    req.strb  = 4'($urandom_range(15));
    req.id    = 5'($urandom_range(31));
    dreq_exp_q.push_back(req);
    mem_sent++;
    core_data_req_i = req;
    core_data_req_valid_i = 1'b1;
  endtask

  // ------------------------------
  // Stimulus and responders
  // ------------------------------
  always @(negedge clk_i) begin
    if (run_en) begin
      if (acc_req_done) begin
        core_acc_req_valid_i = 1'b0;
        acc_req_done = 1'b0;
      end
      if (!core_acc_req_valid_i && acc_sent < NumAcc && outstanding < 31 &&
          $urandom_range(3) != 0) begin
        issue_acc_req();
      end
      if (dreq_done) begin
        core_data_req_valid_i = 1'b0;
        dreq_done = 1'b0;
      end
      if (!core_data_req_valid_i && mem_sent < NumMem && $urandom_range(3) == 0) begin
        issue_mem_req();
      end
      if (sh_resp_done) begin
        sh_acc_resp_valid_i = 1'b0;
        sh_resp_done = 1'b0;
      end
      // Shared unit answers in order after 0 to 5 idle cycles
      if (!sh_acc_resp_valid_i && sh_pend_q.size() > 0) begin
        if (sh_delay < 0) begin
          sh_delay = $urandom_range(5);
        end
        if (sh_delay == 0) begin
          sh_head = sh_pend_q.pop_front();
          sh_acc_resp_i.id    = sh_head.id;
          sh_acc_resp_i.data  = sh_head.arga ^ sh_head.argb;
          sh_acc_resp_i.error = sh_head.argc[0];
          sh_acc_resp_valid_i = 1'b1;
          sh_delay = -1;
        end else begin
          sh_delay--;
        end
      end
      if (dresp_done) begin
        data_resp_valid_i = 1'b0;
        dresp_done = 1'b0;
      end
      if (!data_resp_valid_i && mem_pend_q.size() > 0 && $urandom_range(1) == 0) begin
        data_resp_i = mem_pend_q.pop_front();
        data_resp_valid_i = 1'b1;
      end
      core_acc_resp_ready_i  = ($urandom_range(3) != 0);
      sh_acc_req_ready_i     = ($urandom_range(2) != 0);
      data_req_ready_i       = ($urandom_range(2) != 0);
      core_data_resp_ready_i = ($urandom_range(3) != 0);
    end
  end

  // ------------------------------
  // Monitor and model
  // ------------------------------
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (rst_i || rst_d) begin
      if (core_acc_resp_valid_o || sh_acc_req_valid_o || data_req_valid_o ||
          core_data_resp_valid_o) begin
        report_problem("a valid output is high during or right after reset");
      end
    end
    if (core_acc_req_valid_i && core_acc_req_ready_o) acc_req_done = 1'b1;
    if (sh_acc_resp_valid_i && sh_acc_resp_ready_o) sh_resp_done = 1'b1;
    if (core_data_req_valid_i && core_data_req_ready_o) dreq_done = 1'b1;
    if (data_resp_valid_i && data_resp_ready_o) dresp_done = 1'b1;
    if (sh_acc_req_valid_o && sh_acc_req_ready_i) begin
      if (sh_exp_q.size() == 0) begin
        report_problem("a request reached the shared port that was not sent there");
      end else begin
        check_acc_req("sh_acc_req_o", sh_exp_q.pop_front(), sh_acc_req_o);
      end
      sh_pend_q.push_back(sh_acc_req_o);
    end
    if (core_acc_resp_valid_o && core_acc_resp_ready_i) begin
      if (!exp_busy[core_acc_resp_o.id]) begin
        report_problem($sformatf("response for id %0d that is not outstanding",
                                 core_acc_resp_o.id));
      end else begin
        check_acc_resp("core_acc_resp_o", exp_resp[core_acc_resp_o.id], core_acc_resp_o);
        exp_busy[core_acc_resp_o.id] = 1'b0;
        outstanding--;
        acc_rcvd++;
      end
    end
    if (data_req_valid_o && data_req_ready_i) begin
      if (dreq_exp_q.size() == 0) begin
        report_problem("a memory request appeared that the core did not send");
      end else begin
        check_dreq("data_req_o", dreq_exp_q.pop_front(), data_req_o);
      end
      // Memory answers every request with random content
      mem_rsp.data  = $urandom();
      mem_rsp.id    = 5'($urandom_range(31));
      mem_rsp.write = 1'($urandom_range(1));
      mem_rsp.error = 1'($urandom_range(1));
      mem_pend_q.push_back(mem_rsp);
      dresp_exp_q.push_back(mem_rsp);
    end
    if (core_data_resp_valid_o && core_data_resp_ready_i) begin
      if (dresp_exp_q.size() == 0) begin
        report_problem("a memory response reached the core that memory did not send");
      end else begin
        check_dresp("core_data_resp_o", dresp_exp_q.pop_front(), core_data_resp_o);
      end
      mem_rcvd++;
    end
    rst_d = rst_i;
  end

  initial begin
    void'($urandom(30));
    clk_i = 1'b0;
    rst_i = 1'b1;
    run_en = 1'b0;
    exp_busy = '0;
    core_acc_req_i = '0;
    core_acc_req_valid_i = 1'b0;
    core_acc_resp_ready_i = 1'b0;
    sh_acc_req_ready_i = 1'b0;
    sh_acc_resp_i = '0;
    sh_acc_resp_valid_i = 1'b0;
    core_data_req_i = '0;
    core_data_req_valid_i = 1'b0;
    data_req_ready_i = 1'b0;
    data_resp_i = '0;
    data_resp_valid_i = 1'b0;
    core_data_resp_ready_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    repeat (2) @(posedge clk_i);
    run_en = 1'b1;
    wait (acc_rcvd == NumAcc && mem_rcvd == NumMem);
    // Idle tail catches late duplicates
    repeat (20) @(posedge clk_i);
    if (outstanding != 0 || sh_exp_q.size() != 0 || dreq_exp_q.size() != 0 ||
        dresp_exp_q.size() != 0) begin
      report_problem("transactions were left unfinished at the end of the run");
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog on the cycle counter
  initial begin
    wait (cycle_cnt >= MaxCycles);
    $display("Timeout after %0d cycles, %0d offload and %0d memory responses missing",
             cycle_cnt, NumAcc - acc_rcvd, NumMem - mem_rcvd);
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
logic/cc_pkg.sv
logic/spill_register.sv
logic/int_unit.sv
logic/offload_router.sv
logic/core_complex.sv
tests/tb_core_complex.sv

// ==== Makefile ====
# Verilator build and run of the core complex testbench

VERILATOR ?= verilator
SEED      ?= 30
TOP       ?= tb_core_complex
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

FILELIST := tb.f
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard include/*.svh)
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
